// File: dcache_ctrl.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_ctrl_fsm.sv
logic/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the data cache testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module dcache_tb \
    --Mdir obj_dir -f dcache_ctrl.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vdcache_tb > "$log" 2>&1
status=$?
cat "$log"

[ "$status" -eq 0 ] && ! grep -q "Checks failed" "$log" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: verif/dcache_tb.sv
/*
 * testbench of the data cache controller
 * applies a table of loads and stores through the core handshake
 * and answers the memory port from a word memory model with random delays
 */
`timescale 1ns/1ps

module dcache_tb;

    localparam int NUM_ENTRIES      = 14;
    localparam int RESET_CYCLES     = 8;
    localparam int CYCLES_PER_ENTRY = 200;
    // cycles from the sampling edge in IDLE to core ack on a load hit
    localparam int HIT_ACK_DELAY    = 2;
    localparam int MEM_WORDS        = 16384;

    // loads expect exp_rdata on the core port
    // stores expect exp_rdata in memory once the write is done
    typedef struct packed {
        logic              we;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t wdata;
        dcache_pkg::be_t   be;
        dcache_pkg::word_t exp_rdata;
        int                exp_reads;
    } entry_t;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              core_req_i;
    logic              core_we_i;
    dcache_pkg::addr_t core_addr_i;
    dcache_pkg::word_t core_wdata_i;
    dcache_pkg::be_t   core_be_i;
    logic              core_ack_o;
    dcache_pkg::word_t core_rdata_o;
    logic              mem_req_o;
    logic              mem_we_o;
    dcache_pkg::addr_t mem_addr_o;
    dcache_pkg::word_t mem_wdata_o;
    logic              mem_ack_i;
    dcache_pkg::word_t mem_rdata_i;

    entry_t            entries [NUM_ENTRIES];
    dcache_pkg::word_t mem_words [MEM_WORDS];
    int                mem_reads  = 0;
    int                mem_writes = 0;
    int                checks     = 0;
    int                errors     = 0;
    integer            seed       = 32'h2c7f;

    always #50 clk_i = ~clk_i;

    dcache_top i_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .core_req_i   (core_req_i),
        .core_we_i    (core_we_i),
        .core_addr_i  (core_addr_i),
        .core_wdata_i (core_wdata_i),
        .core_be_i    (core_be_i),
        .core_ack_o   (core_ack_o),
        .core_rdata_o (core_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    // ------------------------------------------------------------
    // expected value model
    // ------------------------------------------------------------
    // memory word at byte address a holds the inverted address above the address
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
        return {~a, a};
    endfunction

    // old word with the enabled bytes taken from the store data
    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::be_t be);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic int draw_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic set_entry(input int idx, input logic we, input dcache_pkg::addr_t addr,
                             input dcache_pkg::word_t wdata, input dcache_pkg::be_t be,
                             input dcache_pkg::word_t exp_rdata, input int exp_reads);
        entries[idx].we        = we;
        entries[idx].addr      = addr;
        entries[idx].wdata     = wdata;
        entries[idx].be        = be;
        entries[idx].exp_rdata = exp_rdata;
        entries[idx].exp_reads = exp_reads;
    endtask

    // lines in set 3 and set 6 first and then A, B and C all in set 9
    task automatic build_entries();
        set_entry(0,  1'b0, 16'h1234, '0, '0, init_word(16'h1234), 4);
        set_entry(1,  1'b0, 16'h1238, '0, '0, init_word(16'h1238), 0);
        set_entry(2,  1'b0, 16'h1234, '0, '0, init_word(16'h1234), 0);
        // partial store hit and read back of the merged word
        set_entry(3,  1'b1, 16'h1230, 32'ha5a5_5a5a, 4'b0101,
                  merge_bytes(init_word(16'h1230), 32'ha5a5_5a5a, 4'b0101), 0);
        set_entry(4,  1'b0, 16'h1230, '0, '0,
                  merge_bytes(init_word(16'h1230), 32'ha5a5_5a5a, 4'b0101), 0);
        // store miss leaves the cache alone
        set_entry(5,  1'b1, 16'h4560, 32'hdead_beef, 4'hf,
                  merge_bytes(init_word(16'h4560), 32'hdead_beef, 4'hf), 0);
        set_entry(6,  1'b0, 16'h4560, '0, '0,
                  merge_bytes(init_word(16'h4560), 32'hdead_beef, 4'hf), 4);
        // A and B fill both ways and C evicts A
        set_entry(7,  1'b0, 16'h1190, '0, '0, init_word(16'h1190), 4);
        set_entry(8,  1'b0, 16'h2294, '0, '0, init_word(16'h2294), 4);
        set_entry(9,  1'b0, 16'h3398, '0, '0, init_word(16'h3398), 4);
        set_entry(10, 1'b0, 16'h2290, '0, '0, init_word(16'h2290), 0);
        // B was hit last so A replaces C
        set_entry(11, 1'b0, 16'h119c, '0, '0, init_word(16'h119c), 4);
        set_entry(12, 1'b0, 16'h2298, '0, '0, init_word(16'h2298), 0);
        set_entry(13, 1'b0, 16'h3390, '0, '0, init_word(16'h3390), 4);
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // one table entry through the core handshake
    // ------------------------------------------------------------
    task automatic run_entry(input int idx);
        entry_t            e;
        dcache_pkg::word_t rdata;
        int                cycles;
        int                reads_before;
        int                writes_before;
        e             = entries[idx];
        reads_before  = mem_reads;
        writes_before = mem_writes;
        @(posedge clk_i);
        core_req_i   <= 1'b1;
        core_we_i    <= e.we;
        core_addr_i  <= e.addr;
        core_wdata_i <= e.wdata;
        core_be_i    <= e.be;
        // IDLE samples the request at this edge
        @(posedge clk_i);
        cycles = 0;
        @(negedge clk_i);
        while (!core_ack_o) begin
            cycles++;
            @(negedge clk_i);
        end
        rdata = core_rdata_o;
        @(posedge clk_i);
        core_req_i <= 1'b0;
        @(negedge clk_i);
        while (core_ack_o) begin
            @(negedge clk_i);
        end
        if (e.we) begin
            // write-through puts the whole merged word into memory
            check_equal($sformatf("entry %0d memory word", idx),
                        mem_words[e.addr[15:2]], e.exp_rdata);
        end else begin
            check_equal($sformatf("entry %0d rdata", idx), rdata, e.exp_rdata);
        end
        check_equal($sformatf("entry %0d memory reads", idx),
                    mem_reads - reads_before, e.exp_reads);
        check_equal($sformatf("entry %0d memory writes", idx),
                    mem_writes - writes_before, e.we ? 1 : 0);
        if (!e.we && e.exp_reads == 0) begin
            check_equal($sformatf("entry %0d hit latency", idx), cycles, HIT_ACK_DELAY);
        end
    endtask

    // ------------------------------------------------------------
    // memory responder with one word per four-phase transfer
    // ------------------------------------------------------------
    initial begin : mem_responder
        int                delay;
        dcache_pkg::addr_t addr;
        logic              we;
        dcache_pkg::word_t wdata;
        mem_ack_i   <= 1'b0;
        mem_rdata_i <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = init_word(dcache_pkg::addr_t'(i * 4));
        end
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                addr  = mem_addr_o;
                we    = mem_we_o;
                wdata = mem_wdata_o;
                delay = draw_delay();
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                if (we) begin
                    mem_words[addr[15:2]] = wdata;
                    mem_writes++;
                end else begin
                    mem_rdata_i <= mem_words[addr[15:2]];
                    mem_reads++;
                end
                mem_ack_i <= 1'b1;
                // release phase
                @(negedge clk_i);
                while (mem_req_o) begin
                    @(negedge clk_i);
                end
                delay = draw_delay();
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                mem_ack_i <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // reset, table loop and closing line
    // ------------------------------------------------------------
    initial begin : stimulus
        rst_ni       <= 1'b0;
        core_req_i   <= 1'b0;
        core_we_i    <= 1'b0;
        core_addr_i  <= '0;
        core_wdata_i <= '0;
        core_be_i    <= '0;
        build_entries();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_equal("core_ack_o after reset", 32'(core_ack_o), 0);
        check_equal("mem_req_o after reset", 32'(mem_req_o), 0);
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            run_entry(idx);
        end
        $display("%0d checks, %0d errors, %0d memory reads, %0d memory writes",
                 checks, errors, mem_reads, mem_writes);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // budget grows with the table length
    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY) @(posedge clk_i);
        $display("timeout: the table did not finish within %0d cycles",
                 RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: verif/dcache_props.sv
/*
 * handshake properties of the data cache controller
 * bound into dcache_top, reports through failing assertions only
 */
`timescale 1ns/1ps

module dcache_props (
    input logic                 clk_i,
    input logic                 rst_ni,
    // monitored core handshake
    input logic                 core_req_i,
    input logic                 core_ack_i,
    // monitored memory handshake
    input logic                 mem_req_i,
    input logic                 mem_ack_i,
    // hit vector of the tag store
    input dcache_pkg::way_vec_t hit_way_i
);

    // ------------------------------------------------------------
    // four-phase rules on both ports
    // ------------------------------------------------------------
    core_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(core_ack_i) |-> core_req_i)
        else $error("core ack rose without a pending core request");

    // a new memory request waits for the previous ack to fall
    mem_req_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_req_i) |-> !mem_ack_i)
        else $error("memory request rose while memory ack was still high");

    // a line lives in at most one way of its set
    hit_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_way_i))
        else $error("tag store reports a hit in more than one way");

endmodule

bind dcache_top dcache_props i_props (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .core_req_i (core_req_i),
    .core_ack_i (core_ack_o),
    .mem_req_i  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .hit_way_i  (hit_way)
);

// File: logic/dcache_top.sv
/*
 * top of the data cache controller
 * tag store and data store side by side, the FSM combines their answers
 */
`timescale 1ns/1ps
`include "dcache_ctrl_config.svh"

module dcache_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    // core port
    input  logic              core_req_i,
    input  logic              core_we_i,
    input  dcache_pkg::addr_t core_addr_i,
    input  dcache_pkg::word_t core_wdata_i,
    input  dcache_pkg::be_t   core_be_i,
    output logic              core_ack_o,
    output dcache_pkg::word_t core_rdata_o,
    // memory port
    output logic              mem_req_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::word_t mem_wdata_o,
    input  logic              mem_ack_i,
    input  dcache_pkg::word_t mem_rdata_i
);

    // tag store wires
    logic                             lookup;
    dcache_pkg::index_t               lookup_index;
    dcache_pkg::tag_t                 lookup_tag;
    logic                             fill;
    dcache_pkg::way_vec_t             fill_way;
    logic                             touch;
    dcache_pkg::way_vec_t             touch_way;
    dcache_pkg::way_vec_t             hit_way;
    dcache_pkg::way_vec_t             victim_way;
    // data store wires
    dcache_pkg::index_t               rd_index;
    dcache_pkg::woff_t                rd_woff;
    dcache_pkg::word_t [`DC_WAYS-1:0] way_words;
    logic                             wr;
    dcache_pkg::way_vec_t             wr_way;
    dcache_pkg::index_t               wr_index;
    dcache_pkg::woff_t                wr_woff;
    dcache_pkg::be_t                  wr_be;
    dcache_pkg::word_t                wr_data;

    dcache_tag_store i_tag_store (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_i       (lookup),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way)
    );

    dcache_data_store i_data_store (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_index_i  (rd_index),
        .rd_woff_i   (rd_woff),
        .wr_i        (wr),
        .wr_way_i    (wr_way),
        .wr_index_i  (wr_index),
        .wr_woff_i   (wr_woff),
        .wr_be_i     (wr_be),
        .wr_data_i   (wr_data),
        .way_words_o (way_words)
    );

    dcache_ctrl_fsm i_ctrl_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .core_req_i     (core_req_i),
        .core_we_i      (core_we_i),
        .core_addr_i    (core_addr_i),
        .core_wdata_i   (core_wdata_i),
        .core_be_i      (core_be_i),
        .core_ack_o     (core_ack_o),
        .core_rdata_o   (core_rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i),
        .lookup_o       (lookup),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .rd_index_o     (rd_index),
        .rd_woff_o      (rd_woff),
        .way_words_i    (way_words),
        .wr_o           (wr),
        .wr_way_o       (wr_way),
        .wr_index_o     (wr_index),
        .wr_woff_o      (wr_woff),
        .wr_be_o        (wr_be),
        .wr_data_o      (wr_data)
    );

endmodule

// File: logic/dcache_ctrl_fsm.sv
/*
 * request sequencing of the write-through data cache
 * serves hits from the stores, refills load misses and writes stores to memory
 */
`timescale 1ns/1ps
`include "dcache_ctrl_config.svh"

module dcache_ctrl_fsm (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // core port
    input  logic                             core_req_i,
    input  logic                             core_we_i,
    input  dcache_pkg::addr_t                core_addr_i,
    input  dcache_pkg::word_t                core_wdata_i,
    input  dcache_pkg::be_t                  core_be_i,
    output logic                             core_ack_o,
    output dcache_pkg::word_t                core_rdata_o,
    // memory port
    output logic                             mem_req_o,
    output logic                             mem_we_o,
    output dcache_pkg::addr_t                mem_addr_o,
    output dcache_pkg::word_t                mem_wdata_o,
    input  logic                             mem_ack_i,
    input  dcache_pkg::word_t                mem_rdata_i,
    // tag store
    output logic                             lookup_o,
    output dcache_pkg::index_t               lookup_index_o,
    output dcache_pkg::tag_t                 lookup_tag_o,
    input  dcache_pkg::way_vec_t             hit_way_i,
    input  dcache_pkg::way_vec_t             victim_way_i,
    output logic                             fill_o,
    output dcache_pkg::way_vec_t             fill_way_o,
    output logic                             touch_o,
    output dcache_pkg::way_vec_t             touch_way_o,
    // data store
    output dcache_pkg::index_t               rd_index_o,
    output dcache_pkg::woff_t                rd_woff_o,
    input  dcache_pkg::word_t [`DC_WAYS-1:0] way_words_i,
    output logic                             wr_o,
    output dcache_pkg::way_vec_t             wr_way_o,
    output dcache_pkg::index_t               wr_index_o,
    output dcache_pkg::woff_t                wr_woff_o,
    output dcache_pkg::be_t                  wr_be_o,
    output dcache_pkg::word_t                wr_data_o
);

    dcache_pkg::fsm_state_e state_d, state_q;
    logic                   ack_d, ack_q;
    logic                   mem_req_d, mem_req_q;
    dcache_pkg::woff_t      cnt_d, cnt_q;
    // latched request and its results
    logic                   we_d, we_q;
    dcache_pkg::addr_t      addr_d, addr_q;
    dcache_pkg::word_t      wdata_d, wdata_q;
    dcache_pkg::be_t        be_d, be_q;
    dcache_pkg::way_vec_t   way_d, way_q;
    dcache_pkg::word_t      rdata_d, rdata_q;

    dcache_pkg::tag_t       req_tag;
    dcache_pkg::index_t     req_index;
    dcache_pkg::woff_t      req_woff;
    dcache_pkg::word_t      hit_word;
    dcache_pkg::word_t      merged_word;
    logic                   refill_st;

    assign req_tag   = addr_q[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign req_index = addr_q[`DC_BYTE_OFF_WIDTH+`DC_WOFF_WIDTH +: `DC_INDEX_WIDTH];
    assign req_woff  = addr_q[`DC_BYTE_OFF_WIDTH +: `DC_WOFF_WIDTH];
    assign refill_st = (state_q == dcache_pkg::REFILL_REQ);

    // parallel lookup straight from the core address
    assign lookup_index_o = core_addr_i[`DC_BYTE_OFF_WIDTH+`DC_WOFF_WIDTH +: `DC_INDEX_WIDTH];
    assign lookup_tag_o   = core_addr_i[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign rd_index_o     = lookup_index_o;
    assign rd_woff_o      = core_addr_i[`DC_BYTE_OFF_WIDTH +: `DC_WOFF_WIDTH];

    // ------------------------------------------------------------
    // way select and store merge
    // ------------------------------------------------------------
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_way_i[w]) begin
                hit_word = way_words_i[w];
            end
        end
        for (int b = 0; b < `DC_BE_WIDTH; b++) begin
            merged_word[8*b +: 8] = be_q[b] ? wdata_q[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    // refill writes whole words at the walking offset, store hits use the request
    assign wr_index_o = req_index;
    assign wr_woff_o  = refill_st ? cnt_q : req_woff;
    assign wr_be_o    = refill_st ? '1 : be_q;
    assign wr_data_o  = refill_st ? mem_rdata_i : wdata_q;

    // memory side, one aligned word per transfer
    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = we_q;
    assign mem_addr_o  = {req_tag, req_index, (we_q ? req_woff : cnt_q),
                          {`DC_BYTE_OFF_WIDTH{1'b0}}};
    assign mem_wdata_o = wdata_q;

    assign core_ack_o   = ack_q;
    assign core_rdata_o = rdata_q;
    assign fill_way_o   = way_q;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        ack_d       = ack_q;
        mem_req_d   = mem_req_q;
        cnt_d       = cnt_q;
        we_d        = we_q;
        addr_d      = addr_q;
        wdata_d     = wdata_q;
        be_d        = be_q;
        way_d       = way_q;
        rdata_d     = rdata_q;
        lookup_o    = 1'b0;
        wr_o        = 1'b0;
        wr_way_o    = '0;
        fill_o      = 1'b0;
        touch_o     = 1'b0;
        touch_way_o = '0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (core_req_i) begin
                    lookup_o = 1'b1;
                    we_d     = core_we_i;
                    addr_d   = core_addr_i;
                    wdata_d  = core_wdata_i;
                    be_d     = core_be_i;
                    state_d  = dcache_pkg::LOOKUP;
                end
            end

            // tag and data results arrive here together
            dcache_pkg::LOOKUP: begin
                if (|hit_way_i) begin
                    touch_o     = 1'b1;
                    touch_way_o = hit_way_i;
                end
                if (!we_q && (|hit_way_i)) begin
                    rdata_d = hit_word;
                    state_d = dcache_pkg::RESPOND;
                end else if (we_q) begin
                    // store hit updates the line, memory always gets the word
                    wr_o      = |hit_way_i;
                    wr_way_o  = hit_way_i;
                    if (|hit_way_i) begin
                        wdata_d = merged_word;
                    end
                    mem_req_d = 1'b1;
                    state_d   = dcache_pkg::MEM_WRITE;
                end else begin
                    way_d     = victim_way_i;
                    cnt_d     = '0;
                    mem_req_d = 1'b1;
                    state_d   = dcache_pkg::REFILL_REQ;
                end
            end

            dcache_pkg::MEM_WRITE: begin
                if (mem_req_q && mem_ack_i) begin
                    mem_req_d = 1'b0;
                end else if (!mem_req_q && !mem_ack_i) begin
                    // answer right after memory releases
                    ack_d   = 1'b1;
                    state_d = dcache_pkg::RESPOND;
                end
            end

            dcache_pkg::REFILL_REQ: begin
                if (mem_ack_i) begin
                    wr_o      = 1'b1;
                    wr_way_o  = way_q;
                    if (cnt_q == req_woff) begin
                        rdata_d = mem_rdata_i;
                    end
                    mem_req_d = 1'b0;
                    state_d   = dcache_pkg::REFILL_RELEASE;
                end
            end

            dcache_pkg::REFILL_RELEASE: begin
                if (!mem_ack_i) begin
                    if (cnt_q == dcache_pkg::woff_t'(`DC_WORDS_PER_LINE-1)) begin
                        fill_o  = 1'b1;
                        state_d = dcache_pkg::RESPOND;
                    end else begin
                        cnt_d     = cnt_q + 1'b1;
                        mem_req_d = 1'b1;
                        state_d   = dcache_pkg::REFILL_REQ;
                    end
                end
            end

            dcache_pkg::RESPOND: begin
                if (!ack_q) begin
                    ack_d = 1'b1;
                end else if (!core_req_i) begin
                    ack_d   = 1'b0;
                    state_d = dcache_pkg::IDLE;
                end
            end

            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= dcache_pkg::IDLE;
            ack_q     <= 1'b0;
            mem_req_q <= 1'b0;
            cnt_q     <= '0;
        end else begin
            state_q   <= state_d;
            ack_q     <= ack_d;
            mem_req_q <= mem_req_d;
            cnt_q     <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        we_q    <= we_d;
        addr_q  <= addr_d;
        wdata_q <= wdata_d;
        be_q    <= be_d;
        way_q   <= way_d;
        rdata_q <= rdata_d;
    end

endmodule

// File: logic/dcache_data_store.sv
/*
 * word arrays of the two ways
 * every way is read in parallel, writes go to one way under byte enables
 */
`timescale 1ns/1ps
`include "dcache_ctrl_config.svh"

module dcache_data_store (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  dcache_pkg::index_t                   rd_index_i,
    input  dcache_pkg::woff_t                    rd_woff_i,
    input  logic                                 wr_i,
    input  dcache_pkg::way_vec_t                 wr_way_i,
    input  dcache_pkg::index_t                   wr_index_i,
    input  dcache_pkg::woff_t                    wr_woff_i,
    input  dcache_pkg::be_t                      wr_be_i,
    input  dcache_pkg::word_t                    wr_data_i,
    output dcache_pkg::word_t [`DC_WAYS-1:0]     way_words_o
);

    // one entry per word, addressed by {index, word offset}
    dcache_pkg::word_t data_mem [`DC_WAYS][`DC_SETS*`DC_WORDS_PER_LINE];

    logic [`DC_INDEX_WIDTH+`DC_WOFF_WIDTH-1:0] rd_addr;
    logic [`DC_INDEX_WIDTH+`DC_WOFF_WIDTH-1:0] wr_addr;

    assign rd_addr = {rd_index_i, rd_woff_i};
    assign wr_addr = {wr_index_i, wr_woff_i};

    // ------------------------------------------------------------
    // synchronous read of all ways
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            way_words_o <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                way_words_o[w] <= data_mem[w][rd_addr];
            end
        end
    end

    // ------------------------------------------------------------
    // byte enabled write into the selected way
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int b = 0; b < `DC_BE_WIDTH; b++) begin
                if (wr_i && wr_way_i[w] && wr_be_i[b]) begin
                    data_mem[w][wr_addr][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: logic/dcache_tag_store.sv
/*
 * valid bits, tags and replacement bits of the two-way cache
 * a lookup registers index and tag, the hit and victim ways follow one cycle later
 */
`timescale 1ns/1ps
`include "dcache_ctrl_config.svh"

module dcache_tag_store (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 lookup_i,
    input  dcache_pkg::index_t   lookup_index_i,
    input  dcache_pkg::tag_t     lookup_tag_i,
    input  logic                 fill_i,
    input  dcache_pkg::way_vec_t fill_way_i,
    input  logic                 touch_i,
    input  dcache_pkg::way_vec_t touch_way_i,
    output dcache_pkg::way_vec_t hit_way_o,
    output dcache_pkg::way_vec_t victim_way_o
);

    logic [`DC_SETS-1:0]  valid_q [`DC_WAYS];
    // one bit per set, names the way to evict next
    logic [`DC_SETS-1:0]  repl_q;
    dcache_pkg::tag_t     tag_mem [`DC_WAYS][`DC_SETS];
    dcache_pkg::index_t   index_q;
    dcache_pkg::tag_t     tag_q;
    dcache_pkg::way_vec_t upd_way;

    // fill wins over touch, both move the victim to the other way
    assign upd_way = fill_i ? fill_way_i : touch_way_i;

    // ------------------------------------------------------------
    // compare against the registered lookup
    // ------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way_o[w] = valid_q[w][index_q] && (tag_mem[w][index_q] == tag_q);
        end
    end

    assign victim_way_o = dcache_pkg::way_vec_t'(1) << repl_q[index_q];

    // lookup registers, valid and replacement state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            index_q <= '0;
            tag_q   <= '0;
            repl_q  <= '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            if (lookup_i) begin
                index_q <= lookup_index_i;
                tag_q   <= lookup_tag_i;
            end
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (fill_i && fill_way_i[w]) begin
                    valid_q[w][index_q] <= 1'b1;
                end
            end
            // way 0 used, so way 1 is next
            if (fill_i || touch_i) begin
                repl_q[index_q] <= upd_way[0];
            end
        end
    end

    // tag array, written on fill with the looked-up tag
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (fill_i && fill_way_i[w]) begin
                tag_mem[w][index_q] <= tag_q;
            end
        end
    end

endmodule

// File: logic/dcache_pkg.sv
/*
 * types shared by the data cache RTL
 * refer to them as dcache_pkg::name
 */
`include "dcache_ctrl_config.svh"

package dcache_pkg;

    // ------------------------------------------------------------
    // address and data
    // ------------------------------------------------------------
    typedef logic [`DC_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`DC_WORD_WIDTH-1:0]  word_t;
    typedef logic [`DC_BE_WIDTH-1:0]    be_t;

    // address fields, high to low: tag, index, word offset, byte offset
    typedef logic [`DC_TAG_WIDTH-1:0]   tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0] index_t;
    typedef logic [`DC_WOFF_WIDTH-1:0]  woff_t;

    // one bit per way, at most one set
    typedef logic [`DC_WAYS-1:0]        way_vec_t;

    // ------------------------------------------------------------
    // controller states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_WRITE,
        REFILL_REQ,
        REFILL_RELEASE,
        RESPOND
    } fsm_state_e;

endpackage

// File: include/dcache_ctrl_config.svh
/*
 * geometry of the data cache, shared by the package and the RTL
 * include wherever a width or a size is needed
 */
`ifndef DCACHE_CTRL_CONFIG_SVH
`define DCACHE_CTRL_CONFIG_SVH

// primary sizes
`define DC_ADDR_WIDTH     16
`define DC_WORD_WIDTH     32
`define DC_WAYS           2
`define DC_SETS           16
`define DC_WORDS_PER_LINE 4

// derived widths of the address fields and byte enables
`define DC_BYTE_OFF_WIDTH $clog2(`DC_WORD_WIDTH / 8)
`define DC_WOFF_WIDTH     $clog2(`DC_WORDS_PER_LINE)
`define DC_INDEX_WIDTH    $clog2(`DC_SETS)
`define DC_TAG_WIDTH      (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_WOFF_WIDTH - `DC_BYTE_OFF_WIDTH)
`define DC_BE_WIDTH       (`DC_WORD_WIDTH / 8)

`endif
